/* hdl/dma_pkg.sv */
package dma_pkg;

   // word address on both memory sides, host and local
   parameter int ADDR_WIDTH = 12;

   // one memory word
   parameter int DATA_WIDTH = 32;

   // descriptor length in words
   parameter int LEN_WIDTH = 12;

   // copy direction
   typedef enum logic {
      HOST_TO_DDR = 1'b0,
      DDR_TO_HOST = 1'b1
   } t_dma_mode;

   // one copy job, 37 bits
   typedef struct packed {
      t_dma_mode             mode;
      logic [ADDR_WIDTH-1:0] src_addr;
      logic [ADDR_WIDTH-1:0] dest_addr;
      logic [LEN_WIDTH-1:0]  length;
   } t_dma_descriptor;

   // request channel payload, 45 bits
   // we low means read
   typedef struct packed {
      logic                  we;
      logic [ADDR_WIDTH-1:0] addr;
      logic [DATA_WIDTH-1:0] wdata;
   } t_mem_req;

   // read response payload
   typedef struct packed {
      logic [DATA_WIDTH-1:0] rdata;
   } t_mem_rsp;

endpackage : dma_pkg

/* hdl/ddr_bank_ram.sv */
module ddr_bank_ram #(
   parameter int DEPTH_WORDS = 1024
) (
   input  logic              clk,
   input  logic              rst_n,
   input  dma_pkg::t_mem_req req,
   input  logic              req_valid,
   output logic              req_ready,
   output dma_pkg::t_mem_rsp rsp,
   output logic              rsp_valid,
   input  logic              rsp_ready
);

   localparam int IDX_WIDTH = $clog2(DEPTH_WORDS);

   logic [dma_pkg::DATA_WIDTH-1:0] mem [DEPTH_WORDS];
   logic [IDX_WIDTH-1:0]           idx;
   logic                           req_fire;

   // upper address bits arrive zeroed from the selector
   assign idx = req.addr[IDX_WIDTH-1:0];

   // writes always go in, a read waits for the pending response to drain
   assign req_ready = req.we || !rsp_valid || rsp_ready;
   assign req_fire  = req_valid && req_ready;

   always_ff @(posedge clk) begin
      if (req_fire && req.we) begin
         mem[idx] <= req.wdata;
      end
      // response data parked until taken
      if (req_fire && !req.we) begin
         rsp.rdata <= mem[idx];
      end
   end

   // valid the cycle after a read is accepted
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rsp_valid <= 1'b0;
      end else if (req_fire && !req.we) begin
         rsp_valid <= 1'b1;
      end else if (rsp_ready) begin
         rsp_valid <= 1'b0;
      end
   end

   // response held until taken
   a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule : ddr_bank_ram

/* hdl/dma_ddr_selector.sv */
module dma_ddr_selector #(
   parameter int NUM_LOCAL_MEM_BANKS = 4
) (
   input  logic              clk,
   input  logic              rst_n,
   // from the copy engine
   input  dma_pkg::t_mem_req ddr_req,
   input  logic              ddr_req_valid,
   output logic              ddr_req_ready,
   output dma_pkg::t_mem_rsp ddr_rsp,
   output logic              ddr_rsp_valid,
   input  logic              ddr_rsp_ready,
   // to the banks
   output dma_pkg::t_mem_req bank_req [NUM_LOCAL_MEM_BANKS],
   output logic [NUM_LOCAL_MEM_BANKS-1:0] bank_req_valid,
   input  logic [NUM_LOCAL_MEM_BANKS-1:0] bank_req_ready,
   input  dma_pkg::t_mem_rsp bank_rsp [NUM_LOCAL_MEM_BANKS],
   input  logic [NUM_LOCAL_MEM_BANKS-1:0] bank_rsp_valid,
   output logic [NUM_LOCAL_MEM_BANKS-1:0] bank_rsp_ready
);

   localparam int SEL_WIDTH = $clog2(NUM_LOCAL_MEM_BANKS);

   logic [SEL_WIDTH-1:0] req_bank;
   logic [SEL_WIDTH-1:0] rd_bank_q;
   logic                 rd_pending_q;
   logic                 rd_accept;
   dma_pkg::t_mem_req    local_req;

   // bank number sits in the top address bits
   assign req_bank = ddr_req.addr[dma_pkg::ADDR_WIDTH-1 -: SEL_WIDTH];

   // bank sees its own offset only
   always_comb begin
      local_req = ddr_req;
      local_req.addr[dma_pkg::ADDR_WIDTH-1 -: SEL_WIDTH] = '0;
   end

   assign ddr_req_ready = bank_req_ready[req_bank];
   assign rd_accept     = ddr_req_valid && ddr_req_ready && !ddr_req.we;

   // idle banks get nothing
   always_comb begin
      for (int b = 0; b < NUM_LOCAL_MEM_BANKS; b++) begin
         bank_req[b]       = '0;
         bank_req_valid[b] = 1'b0;
         bank_rsp_ready[b] = 1'b0;
      end
      bank_req[req_bank]        = local_req;
      bank_req_valid[req_bank]  = ddr_req_valid;
      bank_rsp_ready[rd_bank_q] = ddr_rsp_ready && rd_pending_q;
   end

   // response comes back from whichever bank took the read
   assign ddr_rsp       = bank_rsp[rd_bank_q];
   assign ddr_rsp_valid = bank_rsp_valid[rd_bank_q] && rd_pending_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_pending_q <= 1'b0;
         rd_bank_q    <= '0;
      end else if (rd_accept) begin
         rd_pending_q <= 1'b1;
         rd_bank_q    <= req_bank;
      end else if (ddr_rsp_valid && ddr_rsp_ready) begin
         rd_pending_q <= 1'b0;
      end
   end

   // one read in flight at most
   a_single_read: assert property (@(posedge clk) disable iff (!rst_n)
      rd_pending_q |-> !rd_accept);

endmodule : dma_ddr_selector

/* hdl/dma_copy_engine.sv */
module dma_copy_engine (
   input  logic                     clk,
   input  logic                     rst_n,
   // descriptor port, four-phase
   input  dma_pkg::t_dma_descriptor desc,
   input  logic                     desc_req,
   output logic                     desc_ack,
   // host memory channel
   output dma_pkg::t_mem_req        host_req,
   output logic                     host_req_valid,
   input  logic                     host_req_ready,
   input  dma_pkg::t_mem_rsp        host_rsp,
   input  logic                     host_rsp_valid,
   output logic                     host_rsp_ready,
   // local memory channel
   output dma_pkg::t_mem_req        ddr_req,
   output logic                     ddr_req_valid,
   input  logic                     ddr_req_ready,
   input  dma_pkg::t_mem_rsp        ddr_rsp,
   input  logic                     ddr_rsp_valid,
   output logic                     ddr_rsp_ready
);

   typedef enum logic [2:0] {
      IDLE,
      READ_REQ,
      READ_WAIT,
      WRITE_REQ,
      DONE
   } t_state;

   t_state                           state;
   t_state                           state_next;
   dma_pkg::t_dma_mode               mode_q;
   logic [dma_pkg::ADDR_WIDTH-1:0]   src_addr_q;
   logic [dma_pkg::ADDR_WIDTH-1:0]   dest_addr_q;
   logic [dma_pkg::LEN_WIDTH-1:0]    remaining_q;
   logic [dma_pkg::DATA_WIDTH-1:0]   data_q;
   logic                             src_is_host;
   logic                             src_req_ready;
   logic                             dst_req_ready;
   logic                             rsp_fire;
   logic [dma_pkg::DATA_WIDTH-1:0]   rsp_data;
   dma_pkg::t_mem_req                rd_req;
   dma_pkg::t_mem_req                wr_req;

   // host is the source for HOST_TO_DDR, the local side otherwise
   assign src_is_host = (mode_q == dma_pkg::HOST_TO_DDR);

   assign src_req_ready = src_is_host ? host_req_ready : ddr_req_ready;
   assign dst_req_ready = src_is_host ? ddr_req_ready : host_req_ready;
   assign rsp_fire      = src_is_host ? (host_rsp_valid && host_rsp_ready)
                                      : (ddr_rsp_valid && ddr_rsp_ready);
   assign rsp_data      = src_is_host ? host_rsp.rdata : ddr_rsp.rdata;

   // payloads only change on a state move, so they hold while stalled
   assign rd_req = '{we: 1'b0, addr: src_addr_q, wdata: '0};
   assign wr_req = '{we: 1'b1, addr: dest_addr_q, wdata: data_q};

   // read goes to the source side, write to the other one
   assign host_req       = (state == WRITE_REQ) ? wr_req : rd_req;
   assign ddr_req        = (state == WRITE_REQ) ? wr_req : rd_req;
   assign host_req_valid = ((state == READ_REQ) && src_is_host) ||
                           ((state == WRITE_REQ) && !src_is_host);
   assign ddr_req_valid  = ((state == READ_REQ) && !src_is_host) ||
                           ((state == WRITE_REQ) && src_is_host);
   assign host_rsp_ready = (state == READ_WAIT) && src_is_host;
   assign ddr_rsp_ready  = (state == READ_WAIT) && !src_is_host;

   // ack held until the agent drops req
   assign desc_ack = (state == DONE);

   always_comb begin
      state_next = state;
      case (state)
         IDLE: begin
            // zero length goes straight to ack
            if (desc_req) begin
               state_next = (desc.length == '0) ? DONE : READ_REQ;
            end
         end
         READ_REQ: begin
            if (src_req_ready) begin
               state_next = READ_WAIT;
            end
         end
         READ_WAIT: begin
            if (rsp_fire) begin
               state_next = WRITE_REQ;
            end
         end
         WRITE_REQ: begin
            // last word accepted
            if (dst_req_ready) begin
               state_next = (remaining_q == 1) ? DONE : READ_REQ;
            end
         end
         DONE: begin
            if (!desc_req) begin
               state_next = IDLE;
            end
         end
         default: state_next = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= IDLE;
      end else begin
         state <= state_next;
      end
   end

   // descriptor capture and per-word advance
   always_ff @(posedge clk) begin
      if (state == IDLE && desc_req) begin
         mode_q      <= desc.mode;
         src_addr_q  <= desc.src_addr;
         dest_addr_q <= desc.dest_addr;
         remaining_q <= desc.length;
      end else if (state == WRITE_REQ && dst_req_ready) begin
         src_addr_q  <= src_addr_q + 1'b1;
         dest_addr_q <= dest_addr_q + 1'b1;
         remaining_q <= remaining_q - 1'b1;
      end
      // word parked between read and write
      if (state == READ_WAIT && rsp_fire) begin
         data_q <= rsp_data;
      end
   end

   // request held with its payload until accepted
   a_host_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      host_req_valid && !host_req_ready |=> host_req_valid && $stable(host_req));
   a_ddr_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      ddr_req_valid && !ddr_req_ready |=> ddr_req_valid && $stable(ddr_req));

   // ack only answers a live req
   a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(desc_ack) |-> desc_req);

endmodule : dma_copy_engine

/* hdl/dma_subsystem_top.sv */
module dma_subsystem_top #(
   parameter int NUM_LOCAL_MEM_BANKS = 4
) (
   input  logic                     clk,
   input  logic                     rst_n,
   // descriptor port
   input  dma_pkg::t_dma_descriptor desc,
   input  logic                     desc_req,
   output logic                     desc_ack,
   // host memory, modelled outside
   output dma_pkg::t_mem_req        host_req,
   output logic                     host_req_valid,
   input  logic                     host_req_ready,
   input  dma_pkg::t_mem_rsp        host_rsp,
   input  logic                     host_rsp_valid,
   output logic                     host_rsp_ready
);

   // local address space split evenly across banks
   localparam int BANK_DEPTH = (2 ** dma_pkg::ADDR_WIDTH) / NUM_LOCAL_MEM_BANKS;

   // engine to selector
   dma_pkg::t_mem_req ddr_req;
   logic              ddr_req_valid;
   logic              ddr_req_ready;
   dma_pkg::t_mem_rsp ddr_rsp;
   logic              ddr_rsp_valid;
   logic              ddr_rsp_ready;

   // selector to banks
   dma_pkg::t_mem_req                bank_req [NUM_LOCAL_MEM_BANKS];
   logic [NUM_LOCAL_MEM_BANKS-1:0]   bank_req_valid;
   logic [NUM_LOCAL_MEM_BANKS-1:0]   bank_req_ready;
   dma_pkg::t_mem_rsp                bank_rsp [NUM_LOCAL_MEM_BANKS];
   logic [NUM_LOCAL_MEM_BANKS-1:0]   bank_rsp_valid;
   logic [NUM_LOCAL_MEM_BANKS-1:0]   bank_rsp_ready;

   dma_copy_engine i_engine (
      .clk            (clk),
      .rst_n          (rst_n),
      .desc           (desc),
      .desc_req       (desc_req),
      .desc_ack       (desc_ack),
      .host_req       (host_req),
      .host_req_valid (host_req_valid),
      .host_req_ready (host_req_ready),
      .host_rsp       (host_rsp),
      .host_rsp_valid (host_rsp_valid),
      .host_rsp_ready (host_rsp_ready),
      .ddr_req        (ddr_req),
      .ddr_req_valid  (ddr_req_valid),
      .ddr_req_ready  (ddr_req_ready),
      .ddr_rsp        (ddr_rsp),
      .ddr_rsp_valid  (ddr_rsp_valid),
      .ddr_rsp_ready  (ddr_rsp_ready)
   );

   dma_ddr_selector #(
      .NUM_LOCAL_MEM_BANKS (NUM_LOCAL_MEM_BANKS)
   ) i_selector (
      .clk            (clk),
      .rst_n          (rst_n),
      .ddr_req        (ddr_req),
      .ddr_req_valid  (ddr_req_valid),
      .ddr_req_ready  (ddr_req_ready),
      .ddr_rsp        (ddr_rsp),
      .ddr_rsp_valid  (ddr_rsp_valid),
      .ddr_rsp_ready  (ddr_rsp_ready),
      .bank_req       (bank_req),
      .bank_req_valid (bank_req_valid),
      .bank_req_ready (bank_req_ready),
      .bank_rsp       (bank_rsp),
      .bank_rsp_valid (bank_rsp_valid),
      .bank_rsp_ready (bank_rsp_ready)
   );

   // one RAM per bank
   for (genvar b = 0; b < NUM_LOCAL_MEM_BANKS; b++) begin : gen_bank
      ddr_bank_ram #(
         .DEPTH_WORDS (BANK_DEPTH)
      ) i_bank (
         .clk       (clk),
         .rst_n     (rst_n),
         .req       (bank_req[b]),
         .req_valid (bank_req_valid[b]),
         .req_ready (bank_req_ready[b]),
         .rsp       (bank_rsp[b]),
         .rsp_valid (bank_rsp_valid[b]),
         .rsp_ready (bank_rsp_ready[b])
      );
   end

endmodule : dma_subsystem_top

/* testbench/tb_clock_gen.sv */
module tb_clock_gen (
   output logic clk,
   output logic rst_n
);

   timeunit 1ns;
   timeprecision 100ps;

   localparam int RESET_CYCLES = 16;

   // 8 ns period
   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // released just after a rising edge, same as the other stimulus
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;
   end

endmodule : tb_clock_gen

/* testbench/dma_subsystem_tb.sv */
module dma_subsystem_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int HOST_WORDS = 2 ** dma_pkg::ADDR_WIDTH;
   localparam int NUM_ROWS   = 9;

   // one descriptor row, plus host back-pressure and extra cycles of req held after ack
   typedef struct packed {
      dma_pkg::t_dma_descriptor desc;
      logic                     bp;
      logic [3:0]               hold;
   } t_row;

   // mode, src, dest, length, back-pressure, hold
   t_row rows [NUM_ROWS] = '{
      '{'{dma_pkg::HOST_TO_DDR, 12'h010, 12'h020, 12'd16}, 1'b0, 4'd0},
      '{'{dma_pkg::DDR_TO_HOST, 12'h020, 12'h800, 12'd16}, 1'b0, 4'd4},
      '{'{dma_pkg::HOST_TO_DDR, 12'h100, 12'h040, 12'd8},  1'b0, 4'd0},
      '{'{dma_pkg::HOST_TO_DDR, 12'h200, 12'hC40, 12'd8},  1'b0, 4'd0},
      '{'{dma_pkg::DDR_TO_HOST, 12'h040, 12'h900, 12'd8},  1'b0, 4'd1},
      '{'{dma_pkg::DDR_TO_HOST, 12'hC40, 12'h980, 12'd8},  1'b0, 4'd0},
      '{'{dma_pkg::DDR_TO_HOST, 12'h040, 12'hA00, 12'd0},  1'b0, 4'd2},
      '{'{dma_pkg::HOST_TO_DDR, 12'h400, 12'h3F8, 12'd16}, 1'b1, 4'd0},
      '{'{dma_pkg::DDR_TO_HOST, 12'h3F8, 12'hB00, 12'd16}, 1'b1, 4'd3}
   };

   string row_name [NUM_ROWS] = '{
      "h2d_16", "d2h_round_trip", "h2d_bank0", "h2d_bank3", "d2h_bank0",
      "d2h_bank3", "zero_length", "h2d_backpressure", "d2h_backpressure"
   };

   logic                     clk;
   logic                     rst_n;
   dma_pkg::t_dma_descriptor desc;
   logic                     desc_req;
   logic                     desc_ack;
   dma_pkg::t_mem_req        host_req;
   logic                     host_req_valid;
   logic                     host_req_ready;
   dma_pkg::t_mem_rsp        host_rsp;
   logic                     host_rsp_valid;
   logic                     host_rsp_ready;

   // host memory seen by the DUT, and reference copies of both sides
   logic [dma_pkg::DATA_WIDTH-1:0] host_mem [HOST_WORDS];
   logic [dma_pkg::DATA_WIDTH-1:0] ref_host [HOST_WORDS];
   logic [dma_pkg::DATA_WIDTH-1:0] ref_ddr [HOST_WORDS];
   logic                           host_bp;
   logic [31:0]                    lfsr_state = 32'h79bfd1c8;

   tb_clock_gen i_clock_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   dma_subsystem_top #(
      .NUM_LOCAL_MEM_BANKS (4)
   ) i_dut (
      .clk            (clk),
      .rst_n          (rst_n),
      .desc           (desc),
      .desc_req       (desc_req),
      .desc_ack       (desc_ack),
      .host_req       (host_req),
      .host_req_valid (host_req_valid),
      .host_req_ready (host_req_ready),
      .host_rsp       (host_rsp),
      .host_rsp_valid (host_rsp_valid),
      .host_rsp_ready (host_rsp_ready)
   );

   // fibonacci lfsr, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = {lfsr_state[30:0],
                       lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
         bits = {bits[30:0], lfsr_state[0]};
      end
      return bits;
   endfunction

   task automatic stop_on_failure();
      $display("Some tests failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_word(input string name, input dma_pkg::t_mem_rsp expected,
                             input dma_pkg::t_mem_rsp actual);
      if (actual !== expected) begin
         $display("[FAIL] %s: expected %h, actual %h", name, expected.rdata, actual.rdata);
         stop_on_failure();
      end
   endtask

   task automatic check_desc_ack(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("[FAIL] %s desc_ack: expected %b, actual %b", name, expected, actual);
         stop_on_failure();
      end
   endtask

   // control bits of the host channel
   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
         stop_on_failure();
      end
   endtask

   // dest[k] gets src[k] for k below length, addresses wrap
   task automatic apply_model(input dma_pkg::t_dma_descriptor d);
      logic [dma_pkg::ADDR_WIDTH-1:0] s;
      logic [dma_pkg::ADDR_WIDTH-1:0] t;
      s = d.src_addr;
      t = d.dest_addr;
      for (int k = 0; k < int'(d.length); k++) begin
         if (d.mode == dma_pkg::HOST_TO_DDR) begin
            ref_ddr[t] = ref_host[s];
         end else begin
            ref_host[t] = ref_ddr[s];
         end
         s = s + 1'b1;
         t = t + 1'b1;
      end
   endtask

   // whole host memory, so untouched words are covered too
   task automatic compare_host(input string name);
      dma_pkg::t_mem_rsp exp_word;
      dma_pkg::t_mem_rsp act_word;
      for (int a = 0; a < HOST_WORDS; a++) begin
         exp_word.rdata = ref_host[a];
         act_word.rdata = host_mem[a];
         check_word($sformatf("%s host[%03h]", name, a), exp_word, act_word);
      end
   endtask

   task automatic check_reset_state();
      // first edge applies the synchronous reset
      @(posedge clk);
      @(negedge clk);
      while (!rst_n) begin
         check_desc_ack("reset", 1'b0, desc_ack);
         check_flag("reset host_req_valid", 1'b0, host_req_valid);
         check_flag("reset host_rsp_ready", 1'b0, host_rsp_ready);
         @(negedge clk);
      end
      // first cycle out of reset
      check_desc_ack("after reset", 1'b0, desc_ack);
      check_flag("after reset host_req_valid", 1'b0, host_req_valid);
      check_flag("after reset host_rsp_ready", 1'b0, host_rsp_ready);
   endtask

   // one four-phase handshake per row
   task automatic run_row(input int i);
      string name;
      name = row_name[i];
      @(posedge clk);
      #1;
      desc     = rows[i].desc;
      desc_req = 1'b1;
      host_bp  = rows[i].bp;
      // engine has not seen req yet
      @(negedge clk);
      check_desc_ack(name, 1'b0, desc_ack);
      while (desc_ack !== 1'b1) begin
         @(negedge clk);
      end
      // ack holds while req is kept high
      for (int h = 0; h < int'(rows[i].hold); h++) begin
         @(negedge clk);
         check_desc_ack(name, 1'b1, desc_ack);
      end
      @(posedge clk);
      #1;
      desc_req = 1'b0;
      host_bp  = 1'b0;
      // drop seen on the next edge only
      @(negedge clk);
      check_desc_ack(name, 1'b1, desc_ack);
      @(negedge clk);
      check_desc_ack(name, 1'b0, desc_ack);
      apply_model(rows[i].desc);
      compare_host(name);
   endtask

   // host memory, read data one cycle after acceptance
   initial begin : host_model
      logic              req_fire;
      logic              rsp_fire;
      logic              bp;
      logic [31:0]       ready_bits;
      dma_pkg::t_mem_req req_s;
      host_req_ready = 1'b0;
      host_rsp       = '0;
      host_rsp_valid = 1'b0;
      forever begin
         // sample mid-cycle, act just after the edge
         @(negedge clk);
         req_fire = host_req_valid && host_req_ready;
         rsp_fire = host_rsp_valid && host_rsp_ready;
         req_s    = host_req;
         bp       = host_bp;
         @(posedge clk);
         #1;
         if (rsp_fire) begin
            host_rsp_valid = 1'b0;
         end
         if (req_fire && req_s.we) begin
            host_mem[req_s.addr] = req_s.wdata;
         end
         if (req_fire && !req_s.we) begin
            host_rsp.rdata = host_mem[req_s.addr];
            host_rsp_valid = 1'b1;
         end
         ready_bits     = take_bits(1);
         host_req_ready = bp ? ready_bits[0] : 1'b1;
      end
   end

   // 64 cycles per word plus a fixed margin
   initial begin : watchdog
      int words;
      words = 0;
      for (int i = 0; i < NUM_ROWS; i++) begin
         words += int'(rows[i].desc.length);
      end
      repeat (64 * words + 200) @(posedge clk);
      $display("run timed out, no descriptor completion within %0d cycles", 64 * words + 200);
      stop_on_failure();
   end

   initial begin : main
      desc     = '0;
      desc_req = 1'b0;
      host_bp  = 1'b0;
      // random host contents, mirrored into the model
      for (int a = 0; a < HOST_WORDS; a++) begin
         host_mem[a] = take_bits(32);
         ref_host[a] = host_mem[a];
      end
      check_reset_state();
      for (int i = 0; i < NUM_ROWS; i++) begin
         run_row(i);
      end
      $display("All tests passed");
      $finish;
   end

endmodule : dma_subsystem_tb

/* dma_subsystem.f */
hdl/dma_pkg.sv
hdl/ddr_bank_ram.sv
hdl/dma_ddr_selector.sv
hdl/dma_copy_engine.sv
hdl/dma_subsystem_top.sv
testbench/tb_clock_gen.sv
testbench/dma_subsystem_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = dma_subsystem_tb
FILELIST  = dma_subsystem.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# build and run, exit status is the simulator's
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
